/* logic/track_pkg.sv */
package track_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // One signed correlator sum.
   localparam int ACC_W     = 19;
   // I^2+Q^2 of one arm.
   localparam int POW_W     = 2 * ACC_W;
   localparam int MAG_W     = 19;
   localparam int CA_DPHI_W = 21;
   localparam int TAG_W     = 2;
   // Prompt magnitude on top, code phase increment below.
   localparam int TRACK_W   = MAG_W + CA_DPHI_W;

   typedef logic [TAG_W-1:0] tag_t;

   ////////////////////////////////////////////////////////////////////////////
   // Accumulation word
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic signed [ACC_W-1:0] i;
      logic signed [ACC_W-1:0] q;
   } iq_pair_t;

   // Named view, as the source delivers it.
   typedef struct packed {
      tag_t                    tag;
      logic signed [ACC_W-1:0] i_early;
      logic signed [ACC_W-1:0] q_early;
      logic signed [ACC_W-1:0] i_prompt;
      logic signed [ACC_W-1:0] q_prompt;
      logic signed [ACC_W-1:0] i_late;
      logic signed [ACC_W-1:0] q_late;
   } acc_named_t;

   // Arm view. Index 0 is early, 1 prompt, 2 late.
   typedef struct packed {
      tag_t           tag;
      iq_pair_t [0:2] iq;
   } acc_arm_t;

   typedef union packed {
      acc_named_t named;
      acc_arm_t   arm;
   } acc_word_u;

endpackage

/* logic/acc_fifo.sv */
`timescale 1ns/1ps

module acc_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_wr,
   input  track_pkg::acc_word_u i_wr_data,
   input  logic                 i_rd,
   output logic                 o_empty,
   output track_pkg::acc_word_u o_rd_data
);
   import track_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   acc_word_u        mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             wr_en;
   logic             rd_en;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full    = (count == CNT_W'(FIFO_DEPTH));
   assign o_empty = (count == '0);

   // A result offered while full is dropped.
   assign wr_en = i_wr && !full;
   assign rd_en = i_rd && !o_empty;

   // Fall-through read of the oldest entry.
   assign o_rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* logic/power_pipe.sv */
`timescale 1ns/1ps

module power_pipe (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_empty,
   input  track_pkg::acc_word_u        i_word,
   input  logic                        i_update_done,
   output logic                        o_rd,
   output logic                        o_pow_valid,
   output logic [track_pkg::POW_W-1:0] o_pow_early,
   output logic [track_pkg::POW_W-1:0] o_pow_prompt,
   output logic [track_pkg::POW_W-1:0] o_pow_late,
   output track_pkg::tag_t             o_tag
);
   import track_pkg::*;

   localparam logic [1:0] ARM_EARLY  = 2'd0;
   localparam logic [1:0] ARM_PROMPT = 2'd1;
   localparam logic [1:0] ARM_LATE   = 2'd2;

   logic             busy;
   logic             start;
   logic             sel_valid;
   logic [1:0]       arm_cnt;
   iq_pair_t         sel_iq;
   logic [ACC_W-1:0] abs_i;
   logic [ACC_W-1:0] abs_q;
   logic [POW_W-1:0] sq_i;
   logic [POW_W-1:0] sq_q;
   logic             sq_valid;
   logic [1:0]       sq_arm;
   logic [POW_W-1:0] sum;
   logic             sum_valid;
   logic [1:0]       sum_arm;

   // The most negative sum maps to 2^(ACC_W-1) as an unsigned value.
   function automatic logic [ACC_W-1:0] abs_val(input logic signed [ACC_W-1:0] x);
      return x[ACC_W-1] ? ACC_W'(-x) : ACC_W'(x);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Update sequencing
   ////////////////////////////////////////////////////////////////////////////

   // Only one update after the FIFO at a time.
   assign start     = !busy && !i_empty;
   assign sel_valid = start || (arm_cnt != ARM_EARLY);

   // Drop the word once the late arm has been picked up.
   assign o_rd = sel_valid && (arm_cnt == ARM_LATE);

   assign sel_iq = i_word.arm.iq[arm_cnt];
   assign abs_i  = abs_val(sel_iq.i);
   assign abs_q  = abs_val(sel_iq.q);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy        <= 1'b0;
         arm_cnt     <= ARM_EARLY;
         sq_valid    <= 1'b0;
         sum_valid   <= 1'b0;
         o_pow_valid <= 1'b0;
      end else begin
         if (i_update_done) begin
            busy <= 1'b0;
         end else if (start) begin
            busy <= 1'b1;
         end
         if (sel_valid) begin
            arm_cnt <= (arm_cnt == ARM_LATE) ? ARM_EARLY : arm_cnt + 2'd1;
         end
         sq_valid    <= sel_valid;
         sum_valid   <= sq_valid;
         o_pow_valid <= sum_valid && (sum_arm == ARM_LATE);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Square, sum and capture
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (start) begin
         o_tag <= i_word.arm.tag;
      end
      sq_i    <= POW_W'(abs_i) * POW_W'(abs_i);
      sq_q    <= POW_W'(abs_q) * POW_W'(abs_q);
      sq_arm  <= arm_cnt;
      sum     <= sq_i + sq_q;
      sum_arm <= sq_arm;
      if (sum_valid) begin
         case (sum_arm)
            ARM_EARLY:  o_pow_early  <= sum;
            ARM_PROMPT: o_pow_prompt <= sum;
            default:    o_pow_late   <= sum;
         endcase
      end
   end

endmodule

/* logic/mag_sqrt.sv */
`timescale 1ns/1ps

module mag_sqrt (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_start,
   input  logic [track_pkg::POW_W-1:0] i_power,
   output logic                        o_valid,
   output logic [track_pkg::MAG_W-1:0] o_mag
);
   import track_pkg::*;

   localparam int REM_W = MAG_W + 2;
   localparam int CNT_W = $clog2(MAG_W + 1);

   logic             busy;
   logic [CNT_W-1:0] iter_cnt;
   logic [POW_W-1:0] rad;
   logic [REM_W-1:0] rem;
   logic [POW_W-1:0] rad_src;
   logic [REM_W-1:0] rem_src;
   logic [MAG_W-1:0] root_src;
   logic [REM_W+1:0] rem_sh;
   logic [REM_W+1:0] trial;
   logic             take;

   // First iteration runs straight from the input in the start cycle.
   assign rad_src  = i_start ? i_power : rad;
   assign rem_src  = i_start ? '0 : rem;
   assign root_src = i_start ? '0 : o_mag;

   // Bring down two radicand bits and try root*4+1.
   assign rem_sh = {rem_src, rad_src[POW_W-1 -: 2]};
   assign trial  = (REM_W + 2)'({root_src, 2'b01});
   assign take   = (rem_sh >= trial);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy     <= 1'b0;
         iter_cnt <= '0;
         o_valid  <= 1'b0;
      end else begin
         busy    <= i_start || (busy && (iter_cnt != CNT_W'(1)));
         o_valid <= !i_start && busy && (iter_cnt == CNT_W'(1));
         if (i_start) begin
            iter_cnt <= CNT_W'(MAG_W - 1);
         end else if (busy) begin
            iter_cnt <= iter_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_start || busy) begin
         rad   <= rad_src << 2;
         rem   <= take ? REM_W'(rem_sh - trial) : REM_W'(rem_sh);
         o_mag <= {root_src[MAG_W-2:0], take};
      end
   end

endmodule

/* logic/code_loop.sv */
`timescale 1ns/1ps

module code_loop #(
   parameter int DLL_SHIFT = 2
) (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_valid,
   input  track_pkg::tag_t               i_tag,
   input  logic [track_pkg::MAG_W-1:0]   i_mag_early,
   input  logic [track_pkg::MAG_W-1:0]   i_mag_prompt,
   input  logic [track_pkg::MAG_W-1:0]   i_mag_late,
   input  logic                          i_code_en,
   output logic                          o_wr_en,
   output track_pkg::tag_t               o_addr,
   output logic [track_pkg::TRACK_W-1:0] o_data
);
   import track_pkg::*;

   logic signed [MAG_W:0]       el_diff;
   logic signed [MAG_W:0]       el_shift;
   logic signed [CA_DPHI_W-1:0] ca_dphi;

   // Early minus late, one extra bit for the sign.
   assign el_diff  = $signed({1'b0, i_mag_early}) - $signed({1'b0, i_mag_late});
   assign el_shift = el_diff >>> DLL_SHIFT;

   // Sign-extended loop gain output, zeroed when code tracking is off.
   assign ca_dphi = i_code_en ? CA_DPHI_W'(el_shift) : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wr_en <= 1'b0;
      end else begin
         o_wr_en <= i_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_valid) begin
         o_addr <= i_tag;
         o_data <= {i_mag_prompt, ca_dphi};
      end
   end

endmodule

/* logic/tracking_update.sv */
`timescale 1ns/1ps

module tracking_update #(
   parameter int FIFO_DEPTH = 4,
   parameter int DLL_SHIFT  = 2
) (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_acc_valid,
   input  track_pkg::tag_t                     i_acc_tag,
   input  logic signed [track_pkg::ACC_W-1:0]  i_i_early,
   input  logic signed [track_pkg::ACC_W-1:0]  i_q_early,
   input  logic signed [track_pkg::ACC_W-1:0]  i_i_prompt,
   input  logic signed [track_pkg::ACC_W-1:0]  i_q_prompt,
   input  logic signed [track_pkg::ACC_W-1:0]  i_i_late,
   input  logic signed [track_pkg::ACC_W-1:0]  i_q_late,
   input  logic                                i_track_code_en,
   output logic                                o_track_wr_en,
   output track_pkg::tag_t                     o_track_addr,
   output logic [track_pkg::TRACK_W-1:0]       o_track_data
);
   import track_pkg::*;

   acc_word_u        acc_word;
   acc_word_u        fifo_word;
   logic             fifo_empty;
   logic             fifo_rd;
   logic             pow_valid;
   logic [POW_W-1:0] pow_early;
   logic [POW_W-1:0] pow_prompt;
   logic [POW_W-1:0] pow_late;
   tag_t             pow_tag;
   logic             mag_valid;
   logic [MAG_W-1:0] mag_early;
   logic [MAG_W-1:0] mag_prompt;
   logic [MAG_W-1:0] mag_late;

   assign acc_word.named = '{
      tag:      i_acc_tag,
      i_early:  i_i_early,
      q_early:  i_q_early,
      i_prompt: i_i_prompt,
      q_prompt: i_q_prompt,
      i_late:   i_i_late,
      q_late:   i_q_late
   };

   acc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_wr(i_acc_valid), .i_wr_data(acc_word), .i_rd(fifo_rd),
      .o_empty(fifo_empty), .o_rd_data(fifo_word)
   );

   // The track write closes the update and frees the engine.
   power_pipe u_power (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_empty(fifo_empty), .i_word(fifo_word), .i_update_done(o_track_wr_en),
      .o_rd(fifo_rd), .o_pow_valid(pow_valid),
      .o_pow_early(pow_early), .o_pow_prompt(pow_prompt), .o_pow_late(pow_late),
      .o_tag(pow_tag)
   );

   // All three roots start together and finish together.
   mag_sqrt u_sqrt_early (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(pow_valid), .i_power(pow_early),
      .o_valid(), .o_mag(mag_early)
   );

   mag_sqrt u_sqrt_prompt (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(pow_valid), .i_power(pow_prompt),
      .o_valid(mag_valid), .o_mag(mag_prompt)
   );

   mag_sqrt u_sqrt_late (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(pow_valid), .i_power(pow_late),
      .o_valid(), .o_mag(mag_late)
   );

   code_loop #(.DLL_SHIFT(DLL_SHIFT)) u_code (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_valid(mag_valid), .i_tag(pow_tag),
      .i_mag_early(mag_early), .i_mag_prompt(mag_prompt), .i_mag_late(mag_late),
      .i_code_en(i_track_code_en),
      .o_wr_en(o_track_wr_en), .o_addr(o_track_addr), .o_data(o_track_data)
   );

endmodule

/* dv/tracking_update_chk.sv */
`timescale 1ns/1ps

module tracking_update_chk (
   input logic clk,
   input logic i_rst_n,
   input logic i_acc_valid,
   input logic i_fifo_full,
   input logic i_pow_valid,
   input logic i_track_wr_en
);
   import track_pkg::*;

   int unsigned fail_cnt = 0;

   // One write per update.
   a_single_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_track_wr_en |=> !i_track_wr_en)
      else begin
         $error("track write enable held high for two cycles");
         fail_cnt++;
      end

   // The source must never run ahead of the FIFO.
   a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_acc_valid && i_fifo_full))
      else begin
         $error("accumulation result written while the FIFO is full");
         fail_cnt++;
      end

   // Square roots plus the code loop register.
   a_pow_to_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_pow_valid |-> ##(MAG_W + 1) i_track_wr_en)
      else begin
         $error("no track write after the power capture");
         fail_cnt++;
      end

   a_quiet_after_reset: assert property (@(posedge clk)
      $rose(i_rst_n) |=> !i_track_wr_en)
      else begin
         $error("track write enable high right after reset");
         fail_cnt++;
      end

endmodule

bind tracking_update tracking_update_chk i_chk (
   .clk(clk), .i_rst_n(i_rst_n), .i_acc_valid(i_acc_valid),
   .i_fifo_full(u_fifo.full), .i_pow_valid(pow_valid),
   .i_track_wr_en(o_track_wr_en)
);

/* dv/tracking_update_tb.sv */
`timescale 1ns/1ps

module tracking_update_tb;
   import track_pkg::*;

   localparam int FIFO_DEPTH  = 4;
   localparam int DLL_SHIFT   = 2;
   localparam int CLK_PERIOD  = 8;
   // One update per result in the five tests.
   localparam int N_UPDATES   = 28;
   localparam int CYCLE_LIMIT = N_UPDATES * (MAG_W + 6) + 400;

   logic                    clk;
   logic                    i_rst_n;
   logic                    i_acc_valid;
   tag_t                    i_acc_tag;
   logic signed [ACC_W-1:0] i_i_early;
   logic signed [ACC_W-1:0] i_q_early;
   logic signed [ACC_W-1:0] i_i_prompt;
   logic signed [ACC_W-1:0] i_q_prompt;
   logic signed [ACC_W-1:0] i_i_late;
   logic signed [ACC_W-1:0] i_q_late;
   logic                    i_track_code_en;
   logic                    o_track_wr_en;
   tag_t                    o_track_addr;
   logic [TRACK_W-1:0]      o_track_data;

   int                 error_count;
   int                 check_count;
   int                 test_count;
   int                 cycle_cnt;
   int                 seed;
   tag_t               exp_addr_q[$];
   logic [TRACK_W-1:0] exp_data_q[$];

   tracking_update #(.FIFO_DEPTH(FIFO_DEPTH), .DLL_SHIFT(DLL_SHIFT)) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // Floor of the square root, one result bit at a time from the top.
   function automatic longint unsigned floor_sqrt(input longint unsigned p);
      longint unsigned r;
      longint unsigned t;
      int              b;
      r = 0;
      for (b = 24; b >= 0; b--) begin
         t = r | (64'd1 << b);
         if (t * t <= p) begin
            r = t;
         end
      end
      return r;
   endfunction

   function automatic logic [TRACK_W-1:0] expected_word(input longint ie, input longint qe,
      input longint ip, input longint qp, input longint il, input longint ql,
      input logic code_en);
      longint unsigned      mag_e;
      longint unsigned      mag_p;
      longint unsigned      mag_l;
      longint               diff;
      logic [CA_DPHI_W-1:0] inc;
      mag_e = floor_sqrt(ie * ie + qe * qe);
      mag_p = floor_sqrt(ip * ip + qp * qp);
      mag_l = floor_sqrt(il * il + ql * ql);
      diff  = (longint'(mag_e) - longint'(mag_l)) >>> DLL_SHIFT;
      inc   = code_en ? diff[CA_DPHI_W-1:0] : '0;
      return {mag_p[MAG_W-1:0], inc};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Drive, collect and compare
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_addr(input string name, input tag_t exp, input tag_t act);
      check_count++;
      if (act !== exp) begin
         $display("FAIL %s: address expected %0d, actual %0d", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_data(input string name, input logic [TRACK_W-1:0] exp,
      input logic [TRACK_W-1:0] act);
      check_count++;
      if (act !== exp) begin
         $display("FAIL %s: data expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   // Offers one result for one cycle and queues its expected write.
   task automatic drive_result(input tag_t tag, input int ie, input int qe, input int ip,
      input int qp, input int il, input int ql);
      i_acc_valid = 1'b1;
      i_acc_tag   = tag;
      i_i_early   = ACC_W'(ie);
      i_q_early   = ACC_W'(qe);
      i_i_prompt  = ACC_W'(ip);
      i_q_prompt  = ACC_W'(qp);
      i_i_late    = ACC_W'(il);
      i_q_late    = ACC_W'(ql);
      exp_addr_q.push_back(tag);
      exp_data_q.push_back(expected_word(i_i_early, i_q_early, i_i_prompt, i_q_prompt,
         i_i_late, i_q_late, i_track_code_en));
      @(posedge clk);
      #1;
      i_acc_valid = 1'b0;
   endtask

   task automatic collect_writes(input string name, input int n);
      int seen;
      seen = 0;
      while (seen < n) begin
         @(posedge clk);
         #1;
         if (o_track_wr_en) begin
            if (exp_addr_q.size() == 0) begin
               $display("%s: track write arrived with no result pending", name);
               error_count++;
            end else begin
               check_addr(name, exp_addr_q.pop_front(), o_track_addr);
               check_data(name, exp_data_q.pop_front(), o_track_data);
            end
            seen++;
         end
      end
   endtask

   task automatic report_test(input string name, input int errs_at_start);
      test_count++;
      $display("Test %s done with %0d errors", name, error_count - errs_at_start);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   // Prompt magnitude 10, increment (5 - 0) >>> 2 = 1.
   task automatic test_exact_squares();
      int errs;
      errs = error_count;
      drive_result(2'd0, 3, 4, 6, 8, 0, 0);
      collect_writes("exact_squares", 1);
      report_test("exact_squares", errs);
   endtask

   task automatic test_extreme_sums();
      int errs;
      errs = error_count;
      // Late above early, so the increment goes negative.
      drive_result(2'd1, 100, 0, -262144, -262144, -3000, 4000);
      drive_result(2'd2, -262144, 0, 5, 5, 7, -7);
      collect_writes("extreme_sums", 2);
      report_test("extreme_sums", errs);
   endtask

   task automatic test_code_disabled();
      int errs;
      errs = error_count;
      i_track_code_en = 1'b0;
      drive_result(2'd3, 500, -20, 40, -9, 10, 10);
      collect_writes("code_disabled", 1);
      i_track_code_en = 1'b1;
      report_test("code_disabled", errs);
   endtask

   task automatic test_back_to_back();
      int errs;
      errs = error_count;
      drive_result(2'd2, 1200, -300, 5000, 40, -800, 900);
      drive_result(2'd0, -7, 9, -60000, 2, 15, 15);
      drive_result(2'd3, 0, 0, 1, 1, 2000, -2000);
      drive_result(2'd1, 131071, -131072, 300, -400, 4, 3);
      collect_writes("back_to_back", 4);
      report_test("back_to_back", errs);
   endtask

   task automatic test_random_sums();
      int errs;
      int n;
      errs = error_count;
      for (n = 0; n < 10; n++) begin
         drive_result(tag_t'(2 * n), $random(seed), $random(seed), $random(seed),
            $random(seed), $random(seed), $random(seed));
         drive_result(tag_t'(2 * n + 1), $random(seed), $random(seed), $random(seed),
            $random(seed), $random(seed), $random(seed));
         collect_writes("random_sums", 2);
      end
      report_test("random_sums", errs);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      int assert_fails;
      i_rst_n         = 1'b0;
      i_acc_valid     = 1'b0;
      i_acc_tag       = '0;
      i_i_early       = '0;
      i_q_early       = '0;
      i_i_prompt      = '0;
      i_q_prompt      = '0;
      i_i_late        = '0;
      i_q_late        = '0;
      i_track_code_en = 1'b1;
      error_count     = 0;
      check_count     = 0;
      test_count      = 0;
      seed            = 32'h12b8;
      repeat (2) @(posedge clk);
      #1;
      i_rst_n = 1'b1;
      test_exact_squares();
      test_extreme_sums();
      test_code_disabled();
      test_back_to_back();
      test_random_sums();
      repeat (4) @(posedge clk);
      assert_fails = int'(i_dut.i_chk.fail_cnt);
      error_count += assert_fails;
      $display("%0d tests, %0d checks, %0d assertion failures, %0d errors",
         test_count, check_count, assert_fails, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* tracking_update.f */
logic/track_pkg.sv
logic/acc_fifo.sv
logic/power_pipe.sv
logic/mag_sqrt.sv
logic/code_loop.sv
logic/tracking_update.sv
dv/tracking_update_chk.sv
dv/tracking_update_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the tracking update testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tracking_update_tb -Mdir "$OBJ_DIR" -o tracking_update_sim \
   -f tracking_update.f
if [ $? -ne 0 ]; then
   echo "Compilation failed"
   exit 1
fi

# Let assertion errors run on so the testbench can print its summary.
"./$OBJ_DIR/tracking_update_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1
